// File: logic/alu_pkg.sv
// ALU shared types

package alu_pkg;

	// operation code seen on the op port
	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_XOR  = 3'd2,
		OP_SLT  = 3'd3,
		OP_AND  = 3'd4,
		OP_NAND = 3'd5,
		OP_NOR  = 3'd6,
		OP_OR   = 3'd7
	} alu_op_e;

	// which datapath result reaches the output register
	typedef enum logic [2:0] {
		SEL_SUM = 3'd0, // add and subtract
		SEL_XOR = 3'd1,
		SEL_SLT = 3'd2, // sign of a - b, fixed for overflow
		SEL_AND = 3'd3, // also nor, operands inverted
		SEL_OR  = 3'd4  // also nand, operands inverted
	} result_sel_e;

	// datapath steering, one word per operation
	typedef struct packed {
		result_sel_e result_sel;
		logic        invert_a;
		logic        invert_b;
		logic        carry_in;
		logic        flags_en;   // carry and overflow reported
	} alu_ctrl_t;

	// registered status next to the result
	typedef struct packed {
		logic carry;
		logic overflow;
		logic zero;
	} alu_flags_t;

endpackage

// File: logic/alu_op_decoder.sv
// ALU operation decoder
`timescale 1ns/100ps

module alu_op_decoder
	import alu_pkg::*;
(
	input  alu_op_e   op,
	output alu_ctrl_t ctrl
);

	always_comb begin
		// plain pass-through unless the case says otherwise
		ctrl.result_sel = SEL_SUM;
		ctrl.invert_a   = 1'b0;
		ctrl.invert_b   = 1'b0;
		ctrl.carry_in   = 1'b0;
		ctrl.flags_en   = 1'b0;

		case (op)
			OP_ADD: begin
				ctrl.result_sel = SEL_SUM;
				ctrl.flags_en   = 1'b1;
			end
			OP_SUB: begin
				// a + ~b + 1
				ctrl.result_sel = SEL_SUM;
				ctrl.invert_b   = 1'b1;
				ctrl.carry_in   = 1'b1;
				ctrl.flags_en   = 1'b1;
			end
			OP_XOR: begin
				ctrl.result_sel = SEL_XOR;
			end
			OP_SLT: begin
				// same subtraction, only the sign is kept
				ctrl.result_sel = SEL_SLT;
				ctrl.invert_b   = 1'b1;
				ctrl.carry_in   = 1'b1;
			end
			OP_AND: begin
				ctrl.result_sel = SEL_AND;
			end
			OP_NAND: begin
				// ~a | ~b
				ctrl.result_sel = SEL_OR;
				ctrl.invert_a   = 1'b1;
				ctrl.invert_b   = 1'b1;
			end
			OP_NOR: begin
				// ~a & ~b
				ctrl.result_sel = SEL_AND;
				ctrl.invert_a   = 1'b1;
				ctrl.invert_b   = 1'b1;
			end
			OP_OR: begin
				ctrl.result_sel = SEL_OR;
			end
			default: begin
				ctrl.result_sel = SEL_SUM; // unreachable, all codes used
			end
		endcase
	end

endmodule

// File: logic/alu_logic_unit.sv
// ALU operand conditioning and bitwise logic
`timescale 1ns/100ps

module alu_logic_unit
	import alu_pkg::*;
#(
	parameter int DATA_WIDTH = 32
) (
	input  logic [DATA_WIDTH-1:0] a,
	input  logic [DATA_WIDTH-1:0] b,
	input  alu_ctrl_t             ctrl,
	output logic [DATA_WIDTH-1:0] a_cond,
	output logic [DATA_WIDTH-1:0] b_cond,
	output logic [DATA_WIDTH-1:0] and_res,
	output logic [DATA_WIDTH-1:0] or_res,
	output logic [DATA_WIDTH-1:0] xor_res
);

	logic [DATA_WIDTH-1:0] a_mask; // all ones when a is inverted
	logic [DATA_WIDTH-1:0] b_mask;

	assign a_mask = {DATA_WIDTH{ctrl.invert_a}};
	assign b_mask = {DATA_WIDTH{ctrl.invert_b}};

	// inverted operands feed both the gates and the adder
	assign a_cond = a ^ a_mask;
	assign b_cond = b ^ b_mask;

	// nand and nor come out of or and and by de morgan
	assign and_res = a_cond & b_cond;
	assign or_res  = a_cond | b_cond;
	assign xor_res = a_cond ^ b_cond; // never inverted for xor

endmodule

// File: logic/alu_ripple_adder.sv
// ALU ripple-carry adder
`timescale 1ns/100ps

module alu_ripple_adder #(
	parameter int DATA_WIDTH = 32
) (
	input  logic [DATA_WIDTH-1:0] a_cond,
	input  logic [DATA_WIDTH-1:0] b_cond,
	input  logic                  carry_in,
	output logic [DATA_WIDTH-1:0] sum,
	output logic                  carry,
	output logic                  overflow,
	output logic                  less_than
);

	localparam int MSB = DATA_WIDTH - 1;

	logic [DATA_WIDTH:0] carry_chain; // carry into each bit, top is carry out

	assign carry_chain[0] = carry_in; // 1 for subtract

	// one full adder per bit, lsb first
	for (genvar i = 0; i < DATA_WIDTH; i++) begin : g_full_adder
		logic bit_a;
		logic bit_b;
		logic bit_c;

		assign bit_a = a_cond[i];
		assign bit_b = b_cond[i];
		assign bit_c = carry_chain[i];

		assign sum[i] = bit_a ^ bit_b ^ bit_c;
		assign carry_chain[i+1] = (bit_a & bit_b) | (bit_a & bit_c) | (bit_b & bit_c); // majority
	end

	assign carry = carry_chain[DATA_WIDTH];

	// equals carry into msb xor carry out of msb
	assign overflow = carry ^ a_cond[MSB] ^ b_cond[MSB] ^ sum[MSB];

	// sign of a - b, flipped back when the subtraction wrapped
	assign less_than = sum[MSB] ^ overflow;

endmodule

// File: logic/alu_result_select.sv
// ALU result select and output register
`timescale 1ns/100ps

module alu_result_select
	import alu_pkg::*;
#(
	parameter int DATA_WIDTH = 32
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  op_valid,
	input  alu_ctrl_t             ctrl,
	input  logic [DATA_WIDTH-1:0] sum,
	input  logic [DATA_WIDTH-1:0] and_res,
	input  logic [DATA_WIDTH-1:0] or_res,
	input  logic [DATA_WIDTH-1:0] xor_res,
	input  logic                  carry,
	input  logic                  overflow,
	input  logic                  less_than,
	output logic [DATA_WIDTH-1:0] out,
	output alu_flags_t            flags,
	output logic                  result_valid
);

	logic [DATA_WIDTH-1:0] result_next;
	alu_flags_t            flags_next;

	// only one source reaches the register
	always_comb begin
		case (ctrl.result_sel)
			SEL_SUM: result_next = sum;
			SEL_XOR: result_next = xor_res;
			SEL_SLT: result_next = {DATA_WIDTH{less_than}}; // all ones or all zeros
			SEL_AND: result_next = and_res;
			SEL_OR:  result_next = or_res;
			default: result_next = sum;
		endcase
	end

	always_comb begin
		flags_next.carry    = carry & ctrl.flags_en;    // add and sub only
		flags_next.overflow = overflow & ctrl.flags_en;
		flags_next.zero     = ~|result_next;
	end

	// the only state in the ALU
	always_ff @(posedge clk) begin
		if (reset) begin
			out          <= '0;
			flags        <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= op_valid; // one-cycle pulse per accepted op
			if (op_valid) begin
				out   <= result_next;
				flags <= flags_next;
			end
		end
	end

endmodule

// File: logic/alu_top.sv
// ALU top level
`timescale 1ns/100ps

module alu_top
	import alu_pkg::*;
#(
	parameter int DATA_WIDTH = 32
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  op_valid,
	input  alu_op_e               op,
	input  logic [DATA_WIDTH-1:0] a,
	input  logic [DATA_WIDTH-1:0] b,
	output logic [DATA_WIDTH-1:0] out,
	output alu_flags_t            flags,
	output logic                  result_valid
);

	alu_ctrl_t             ctrl;
	logic [DATA_WIDTH-1:0] a_cond;
	logic [DATA_WIDTH-1:0] b_cond;
	logic [DATA_WIDTH-1:0] and_res;
	logic [DATA_WIDTH-1:0] or_res;
	logic [DATA_WIDTH-1:0] xor_res;
	logic [DATA_WIDTH-1:0] sum;
	logic                  carry;
	logic                  overflow;
	logic                  less_than;

	alu_op_decoder alu_op_decoder_inst (
		.op   (op),
		.ctrl (ctrl)
	);

	alu_logic_unit #(
		.DATA_WIDTH (DATA_WIDTH)
	) alu_logic_unit_inst (
		.a       (a),
		.b       (b),
		.ctrl    (ctrl),
		.a_cond  (a_cond),
		.b_cond  (b_cond),
		.and_res (and_res),
		.or_res  (or_res),
		.xor_res (xor_res)
	);

	alu_ripple_adder #(
		.DATA_WIDTH (DATA_WIDTH)
	) alu_ripple_adder_inst (
		.a_cond    (a_cond),
		.b_cond    (b_cond),
		.carry_in  (ctrl.carry_in),
		.sum       (sum),
		.carry     (carry),
		.overflow  (overflow),
		.less_than (less_than)
	);

	alu_result_select #(
		.DATA_WIDTH (DATA_WIDTH)
	) alu_result_select_inst (
		.clk          (clk),
		.reset        (reset),
		.op_valid     (op_valid),
		.ctrl         (ctrl),
		.sum          (sum),
		.and_res      (and_res),
		.or_res       (or_res),
		.xor_res      (xor_res),
		.carry        (carry),
		.overflow     (overflow),
		.less_than    (less_than),
		.out          (out),
		.flags        (flags),
		.result_valid (result_valid)
	);

endmodule

// File: tb/alu_tb.sv
// ALU testbench
`timescale 1ns/100ps

module alu_tb
	import alu_pkg::*;
();

	localparam int DATA_WIDTH     = 32;
	localparam int MSB            = DATA_WIDTH - 1;
	localparam int RESULT_TIMEOUT = 20; // cycles
	localparam int RANDOM_OPS     = 300;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] out;
		alu_flags_t            flags;
	} expect_t;

	logic                  clk;
	logic                  reset;
	logic                  op_valid;
	alu_op_e               op;
	logic [DATA_WIDTH-1:0] a;
	logic [DATA_WIDTH-1:0] b;
	logic [DATA_WIDTH-1:0] out;
	alu_flags_t            flags;
	logic                  result_valid;

	expect_t exp_rec;            // last accepted op, as the model sees it
	logic    exp_valid;
	string   exp_name = "reset";
	string   phase_name = "reset";
	logic    reset_q = 1'b0;
	logic    armed = 1'b0;       // outputs known after the first edge
	integer  seed = 32'h8ac8;
	int      ops_issued = 0;
	int      results_seen = 0;

	alu_top #(
		.DATA_WIDTH (DATA_WIDTH)
	) alu_top_inst (
		.clk          (clk),
		.reset        (reset),
		.op_valid     (op_valid),
		.op           (op),
		.a            (a),
		.b            (b),
		.out          (out),
		.flags        (flags),
		.result_valid (result_valid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [DATA_WIDTH-1:0] corner_value(input logic [1:0] idx);
		case (idx)
			2'd0: return '0;
			2'd1: return '1;
			2'd2: return {1'b1, {(DATA_WIDTH-1){1'b0}}}; // most negative
			default: return {1'b0, {(DATA_WIDTH-1){1'b1}}}; // most positive
		endcase
	endfunction

	// expected result straight from the operation definitions
	function automatic expect_t model_op(input alu_op_e code, input logic [DATA_WIDTH-1:0] x,
			input logic [DATA_WIDTH-1:0] y);
		expect_t               res;
		logic [DATA_WIDTH:0]   wide;
		logic [DATA_WIDTH-1:0] y_add;
		logic                  is_sub;

		res    = '0;
		is_sub = (code == OP_SUB);
		y_add  = is_sub ? ~y : y;
		case (code)
			OP_ADD, OP_SUB: begin
				wide = {1'b0, x} + {1'b0, y_add} + {{DATA_WIDTH{1'b0}}, is_sub};
				res.out = wide[DATA_WIDTH-1:0];
				res.flags.carry = wide[DATA_WIDTH];
				// same-signed operands, result of the other sign
				res.flags.overflow = (x[MSB] == y_add[MSB]) && (res.out[MSB] != x[MSB]);
			end
			OP_SLT:  res.out = ($signed(x) < $signed(y)) ? '1 : '0;
			OP_XOR:  res.out = x ^ y;
			OP_AND:  res.out = x & y;
			OP_OR:   res.out = x | y;
			OP_NAND: res.out = ~(x & y);
			OP_NOR:  res.out = ~(x | y);
			default: res.out = '0;
		endcase
		res.flags.zero = (res.out == '0);
		return res;
	endfunction

	task automatic report_mismatch(input string name, input logic [DATA_WIDTH-1:0] expected,
			input logic [DATA_WIDTH-1:0] actual);
		$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		$display("*** TEST FAILED ***");
		$fatal(1, "output mismatch in %s", name);
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "%s", reason);
	endtask

	// model record loads on the same edge as the DUT register
	always @(posedge clk) begin
		reset_q <= reset;
		armed   <= 1'b1;
		if (reset) begin
			exp_rec   <= '0;
			exp_valid <= 1'b0;
		end else begin
			exp_valid <= op_valid;
			if (op_valid) begin
				exp_rec  <= model_op(op, a, b);
				exp_name = {phase_name, " ", op.name()};
			end
		end
	end

	always @(negedge clk) begin
		if (result_valid === 1'b1)
			results_seen <= results_seen + 1;
	end

	// outputs sampled mid-cycle, well away from the register edge
	a_reset_out: assert property (@(negedge clk) reset_q |-> out == '0)
		else report_mismatch("reset out", '0, out);
	a_reset_flags: assert property (@(negedge clk) reset_q |-> flags == '0)
		else report_mismatch("reset flags", '0, {29'd0, flags});
	a_reset_valid: assert property (@(negedge clk) reset_q |-> result_valid == 1'b0)
		else report_mismatch("reset result_valid", '0, {31'd0, result_valid});
	a_valid: assert property (@(negedge clk) armed && !reset_q |-> result_valid == exp_valid)
		else report_mismatch({"valid timing ", exp_name}, {31'd0, exp_valid},
			{31'd0, result_valid});
	a_out: assert property (@(negedge clk) result_valid |-> out == exp_rec.out)
		else report_mismatch({"out ", exp_name}, exp_rec.out, out);
	a_flags: assert property (@(negedge clk) result_valid |-> flags == exp_rec.flags)
		else report_mismatch({"flags ", exp_name}, {29'd0, exp_rec.flags}, {29'd0, flags});
	a_hold_out: assert property (@(negedge clk)
			armed && !reset_q && !result_valid |-> out == exp_rec.out)
		else report_mismatch({"hold out ", exp_name}, exp_rec.out, out);
	a_hold_flags: assert property (@(negedge clk)
			armed && !reset_q && !result_valid |-> flags == exp_rec.flags)
		else report_mismatch({"hold flags ", exp_name}, {29'd0, exp_rec.flags}, {29'd0, flags});

	task automatic issue_op(input alu_op_e code, input logic [DATA_WIDTH-1:0] x,
			input logic [DATA_WIDTH-1:0] y);
		@(posedge clk);
		op_valid <= 1'b1;
		op       <= code;
		a        <= x;
		b        <= y;
		ops_issued++;
	endtask

	// operands keep moving while nothing is issued
	task automatic idle_cycle();
		logic [DATA_WIDTH-1:0] x;
		logic [DATA_WIDTH-1:0] y;

		x = $random(seed);
		y = $random(seed);
		@(posedge clk);
		op_valid <= 1'b0;
		op       <= alu_op_e'(3'(x));
		a        <= x;
		b        <= y;
	endtask

	task automatic wait_results();
		int waited;

		waited = 0;
		@(posedge clk);
		op_valid <= 1'b0;
		while (results_seen != ops_issued && waited < RESULT_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (results_seen != ops_issued)
			abort_run("timeout while waiting for result_valid");
	endtask

	task automatic single_op(input alu_op_e code, input logic [DATA_WIDTH-1:0] x,
			input logic [DATA_WIDTH-1:0] y);
		issue_op(code, x, y);
		wait_results();
		idle_cycle();
		idle_cycle();
	endtask

	task automatic draw_operand(output logic [DATA_WIDTH-1:0] v);
		logic [DATA_WIDTH-1:0] rnd;

		rnd = $random(seed);
		if (rnd[2:0] == 3'd0)
			v = corner_value(rnd[4:3]); // one draw in eight is a corner
		else
			v = $random(seed);
	endtask

	initial begin
		alu_op_e               code;
		logic [DATA_WIDTH-1:0] x;
		logic [DATA_WIDTH-1:0] y;
		logic [DATA_WIDTH-1:0] rnd;

		reset    <= 1'b1;
		op_valid <= 1'b0;
		op       <= OP_ADD;
		a        <= '0;
		b        <= '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// every op over every pair of corners, back to back
		phase_name = "corner";
		for (int k = 0; k < 8; k++) begin
			for (int i = 0; i < 4; i++) begin
				for (int j = 0; j < 4; j++)
					issue_op(alu_op_e'(k[2:0]), corner_value(i[1:0]), corner_value(j[1:0]));
			end
		end
		wait_results();

		phase_name = "directed";
		single_op(OP_ADD, 32'h7fff_ffff, 32'h0000_0001); // signed overflow
		single_op(OP_ADD, 32'hffff_ffff, 32'h0000_0001); // carry and zero
		single_op(OP_SUB, 32'h8000_0000, 32'h0000_0001); // signed overflow
		single_op(OP_SUB, 32'h0000_0005, 32'h0000_0005);
		single_op(OP_SLT, 32'h8000_0000, 32'h7fff_ffff); // subtraction wraps
		single_op(OP_SLT, 32'h7fff_ffff, 32'h8000_0000);
		single_op(OP_SLT, 32'hffff_ffff, 32'h0000_0000);

		// reset again over a live result, op_valid held high
		single_op(OP_ADD, 32'hffff_ffff, 32'hffff_ffff); // carry, nonzero out
		@(posedge clk);
		reset    <= 1'b1;
		op_valid <= 1'b1;
		repeat (5) @(posedge clk);
		reset    <= 1'b0;
		op_valid <= 1'b0;

		phase_name = "random";
		for (int n = 0; n < RANDOM_OPS; n++) begin
			rnd  = $random(seed);
			code = alu_op_e'(3'(rnd));
			draw_operand(x);
			draw_operand(y);
			issue_op(code, x, y);
			if (rnd[4:3] == 2'd0)
				idle_cycle();
		end
		wait_results();
		repeat (3) idle_cycle();

		if (results_seen == ops_issued) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			abort_run("number of results differs from number of issued ops");
		end
	end

endmodule

// File: build.f
logic/alu_pkg.sv
logic/alu_op_decoder.sv
logic/alu_logic_unit.sv
logic/alu_ripple_adder.sv
logic/alu_result_select.sv
logic/alu_top.sv
tb/alu_tb.sv

// File: Makefile
# Verilator build and run for the ALU

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
LINTFLAGS ?= --lint-only --timing --assert --timescale 1ns/100ps
TOP       ?= alu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass message shows up in the output
run: build
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
